/* flist.f */
src/core_pkg.sv
src/host_bus_pkg.sv
src/mem_write_arbiter.sv
src/control_path.sv
src/operand_translate.sv
src/data_path.sv
src/host_loader.sv
src/scalar_cpu.sv
verif/tb_scalar_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scalar core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_scalar_cpu -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_scalar_cpu
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0

/* src/control_path.sv */
// Program counter and instruction memory, the F stage of the pipeline

`timescale 1ns/1ps

module control_path #(
    parameter int I_ADDR_WIDTH = 6
) (
    input  logic                            clock,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            stall,
    input  logic                            imem_we,
    input  logic [I_ADDR_WIDTH-1:0]         imem_waddr,
    input  logic [core_pkg::WORD_WIDTH-1:0] imem_wdata,
    output logic [core_pkg::WORD_WIDTH-1:0] instr,
    output logic                            instr_valid
);

    logic [core_pkg::WORD_WIDTH-1:0] imem [2**I_ADDR_WIDTH];
    logic [I_ADDR_WIDTH-1:0]         pc;

    // Host writes land whenever they come, fetch follows the stall
    always_ff @(posedge clock) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
        if (!stall) begin
            instr <= imem[pc];
        end
    end

    // PC wraps at the end of the program memory
    always_ff @(posedge clock) begin
        if (!rst_n || !run) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else if (!stall) begin
            instr_valid <= run;
        end
    end

endmodule

/* src/core_pkg.sv */
// Word and instruction field widths, opcodes and the I/O addresses of the core

package core_pkg;

    localparam int WORD_WIDTH = 32;

    // Instruction layout from the top bit down: opcode, D, A, B
    localparam int OPCODE_WIDTH = 4;
    localparam int D_WIDTH = 10;
    localparam int A_WIDTH = 9;
    localparam int B_WIDTH = 9;

    // A and B memories, 512 words each
    localparam int MEM_ADDR_WIDTH = 9;
    localparam int MEM_DEPTH = 2 ** MEM_ADDR_WIDTH;

    // The input port hides the last A word
    localparam logic [A_WIDTH-1:0] IO_READ_ADDR = 9'd511;

    // First D address past the memories is the output port
    localparam logic [D_WIDTH-1:0] IO_WRITE_ADDR = 10'd512;

    // Unlisted codes behave as NOP
    typedef enum logic [OPCODE_WIDTH-1:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,
        AND    = 4'd3,
        OR     = 4'd4,
        XOR    = 4'd5,
        PASS_A = 4'd6
    } opcode_t;

endpackage

/* src/data_path.sv */
// A/B operand memories, ALU and I/O ports, the R and X stages

`timescale 1ns/1ps

module data_path (
    input  logic                                clock,
    input  logic                                rst_n,
    input  core_pkg::opcode_t                   op,
    input  logic [core_pkg::D_WIDTH-1:0]        d_addr,
    input  logic [core_pkg::A_WIDTH-1:0]        a_addr,
    input  logic [core_pkg::B_WIDTH-1:0]        b_addr,
    input  logic                                op_valid,
    input  logic [core_pkg::WORD_WIDTH-1:0]     io_in,
    input  logic                                io_in_empty,
    input  logic                                io_out_full,
    output logic                                stall,
    output logic                                io_rden,
    output logic [core_pkg::WORD_WIDTH-1:0]     io_out,
    output logic                                io_wren,
    output logic                                core_we,
    output logic [core_pkg::MEM_ADDR_WIDTH-1:0] core_waddr,
    output logic [core_pkg::WORD_WIDTH-1:0]     core_wdata,
    input  logic                                mem_we,
    input  logic [core_pkg::MEM_ADDR_WIDTH-1:0] mem_waddr,
    input  logic [core_pkg::WORD_WIDTH-1:0]     mem_wdata
);

    logic [core_pkg::WORD_WIDTH-1:0] a_mem [core_pkg::MEM_DEPTH];
    logic [core_pkg::WORD_WIDTH-1:0] b_mem [core_pkg::MEM_DEPTH];
    logic [core_pkg::WORD_WIDTH-1:0] a_rdata;
    logic [core_pkg::WORD_WIDTH-1:0] b_rdata;
    logic [core_pkg::WORD_WIDTH-1:0] a_val;
    logic [core_pkg::WORD_WIDTH-1:0] result;
    core_pkg::opcode_t               x_op;
    logic [core_pkg::D_WIDTH-1:0]    x_d_addr;
    logic                            x_a_io;
    logic                            x_valid;
    logic                            active;
    logic                            x_live;
    logic                            reads_in;
    logic                            writes_out;

    // Both memories take every write, reads hold during a stall
    always_ff @(posedge clock) begin
        if (mem_we) begin
            a_mem[mem_waddr] <= mem_wdata;
            b_mem[mem_waddr] <= mem_wdata;
        end
        if (!stall) begin
            a_rdata <= a_mem[a_addr];
            b_rdata <= b_mem[b_addr];
            x_op <= op;
            x_d_addr <= d_addr;
            x_a_io <= (a_addr == core_pkg::IO_READ_ADDR);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            x_valid <= 1'b0;
        end else if (!stall) begin
            x_valid <= op_valid;
        end
    end

    // ------------------------------------------------------------------------
    // ALU

    always_comb begin
        a_val = x_a_io ? io_in : a_rdata;
        active = 1'b1;
        case (x_op)
            core_pkg::ADD:    result = a_val + b_rdata;
            core_pkg::SUB:    result = a_val - b_rdata;
            core_pkg::AND:    result = a_val & b_rdata;
            core_pkg::OR:     result = a_val | b_rdata;
            core_pkg::XOR:    result = a_val ^ b_rdata;
            core_pkg::PASS_A: result = a_val;
            default: begin
                result = '0;
                active = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // I/O handshake and stall

    assign x_live = x_valid && active;
    assign reads_in = x_live && x_a_io;
    assign writes_out = x_live && (x_d_addr == core_pkg::IO_WRITE_ADDR);
    assign stall = (reads_in && io_in_empty) || (writes_out && io_out_full);

    // Show-ahead input, the word is taken in the cycle rden is high
    assign io_rden = reads_in && !stall;

    assign core_we = x_live && !x_d_addr[core_pkg::D_WIDTH-1] && !stall;
    assign core_waddr = x_d_addr[core_pkg::MEM_ADDR_WIDTH-1:0];
    assign core_wdata = result;

    always_ff @(posedge clock) begin
        if (writes_out && !stall) begin
            io_out <= result;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_wren <= 1'b0;
        end else begin
            io_wren <= writes_out && !stall;
        end
    end

endmodule

/* src/host_bus_pkg.sv */
// AXI4-Lite response codes and the host word address map of the loader

package host_bus_pkg;

    localparam int HOST_ADDR_WIDTH = 16;

    // Region select sits in word address bits 13:12
    localparam int REGION_LSB = 12;

    typedef enum logic [1:0] {
        REGION_IMEM   = 2'd0,
        REGION_DMEM   = 2'd1,
        REGION_OFFSET = 2'd2,
        REGION_NONE   = 2'd3
    } host_region_t;

    // Words inside the offset region
    localparam logic [1:0] OFFSET_A = 2'd0;
    localparam logic [1:0] OFFSET_B = 2'd1;
    localparam logic [1:0] OFFSET_D = 2'd2;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'd0,
        RESP_SLVERR = 2'd2
    } axi_resp_t;

endpackage

/* src/host_loader.sv */
// AXI4-Lite write slave that loads program, data and offsets

`timescale 1ns/1ps

module host_loader #(
    parameter int I_ADDR_WIDTH = 6
) (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     awvalid,
    output logic                                     awready,
    input  logic [host_bus_pkg::HOST_ADDR_WIDTH-1:0] awaddr,
    input  logic                                     wvalid,
    output logic                                     wready,
    input  logic [core_pkg::WORD_WIDTH-1:0]          wdata,
    output logic                                     bvalid,
    input  logic                                     bready,
    output host_bus_pkg::axi_resp_t                  bresp,
    output logic                                     imem_we,
    output logic [I_ADDR_WIDTH-1:0]                  imem_waddr,
    output logic [core_pkg::WORD_WIDTH-1:0]          imem_wdata,
    output logic                                     offset_we,
    output logic [1:0]                               offset_sel,
    output logic [core_pkg::MEM_ADDR_WIDTH-1:0]      offset_wdata,
    output logic                                     host_req,
    output logic [core_pkg::MEM_ADDR_WIDTH-1:0]      host_waddr,
    output logic [core_pkg::WORD_WIDTH-1:0]          host_wdata,
    input  logic                                     host_gnt
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_GNT,
        RESP
    } state_t;

    state_t                              state;
    host_bus_pkg::host_region_t          region;
    logic                                accept;
    logic                                waiting;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0] held_addr;
    logic [core_pkg::WORD_WIDTH-1:0]     held_data;

    assign region = host_bus_pkg::host_region_t'(awaddr[host_bus_pkg::REGION_LSB +: 2]);
    assign accept = (state == IDLE) && awvalid && wvalid;
    assign waiting = (state == WAIT_GNT);
    assign awready = accept;
    assign wready = accept;
    assign bvalid = (state == RESP);

    assign imem_we = accept && (region == host_bus_pkg::REGION_IMEM);
    assign imem_waddr = awaddr[I_ADDR_WIDTH-1:0];
    assign imem_wdata = wdata;
    assign offset_we = accept && (region == host_bus_pkg::REGION_OFFSET);
    assign offset_sel = awaddr[1:0];
    assign offset_wdata = wdata[core_pkg::MEM_ADDR_WIDTH-1:0];

    // Data write is offered in the accept cycle and held until granted
    assign host_req = (accept && (region == host_bus_pkg::REGION_DMEM)) || waiting;
    assign host_waddr = waiting ? held_addr : awaddr[core_pkg::MEM_ADDR_WIDTH-1:0];
    assign host_wdata = waiting ? held_data : wdata;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= (host_req && !host_gnt) ? WAIT_GNT : RESP;
                    end
                end
                WAIT_GNT: begin
                    if (host_gnt) begin
                        state <= RESP;
                    end
                end
                RESP: begin
                    if (bready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held_addr <= awaddr[core_pkg::MEM_ADDR_WIDTH-1:0];
            held_data <= wdata;
            bresp <= (region == host_bus_pkg::REGION_NONE) ? host_bus_pkg::RESP_SLVERR
                                                           : host_bus_pkg::RESP_OKAY;
        end
    end

endmodule

/* src/mem_write_arbiter.sv */
// Fixed-priority arbiter for the shared A/B memory write port

`timescale 1ns/1ps

module mem_write_arbiter (
    input  logic                                core_we,
    input  logic [core_pkg::MEM_ADDR_WIDTH-1:0] core_waddr,
    input  logic [core_pkg::WORD_WIDTH-1:0]     core_wdata,
    input  logic                                host_req,
    input  logic [core_pkg::MEM_ADDR_WIDTH-1:0] host_waddr,
    input  logic [core_pkg::WORD_WIDTH-1:0]     host_wdata,
    output logic                                host_gnt,
    output logic                                mem_we,
    output logic [core_pkg::MEM_ADDR_WIDTH-1:0] mem_waddr,
    output logic [core_pkg::WORD_WIDTH-1:0]     mem_wdata
);

    // Core results never wait, the host retries next cycle
    assign host_gnt = host_req && !core_we;
    assign mem_we = core_we || host_req;
    assign mem_waddr = core_we ? core_waddr : host_waddr;
    assign mem_wdata = core_we ? core_wdata : host_wdata;

endmodule

/* src/operand_translate.sv */
// Instruction decode and default-offset translation, the T stage

`timescale 1ns/1ps

module operand_translate (
    input  logic                                clock,
    input  logic                                rst_n,
    input  logic                                stall,
    input  logic [core_pkg::WORD_WIDTH-1:0]     instr,
    input  logic                                instr_valid,
    input  logic                                offset_we,
    input  logic [1:0]                          offset_sel,
    input  logic [core_pkg::MEM_ADDR_WIDTH-1:0] offset_wdata,
    output core_pkg::opcode_t                   op,
    output logic [core_pkg::D_WIDTH-1:0]        d_addr,
    output logic [core_pkg::A_WIDTH-1:0]        a_addr,
    output logic [core_pkg::B_WIDTH-1:0]        b_addr,
    output logic                                op_valid
);

    localparam int AB_WIDTH = core_pkg::A_WIDTH + core_pkg::B_WIDTH;
    localparam int D_PAD = core_pkg::D_WIDTH - core_pkg::MEM_ADDR_WIDTH;

    logic [core_pkg::MEM_ADDR_WIDTH-1:0] a_offset;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0] b_offset;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0] d_offset;
    logic [core_pkg::OPCODE_WIDTH-1:0]   f_op;
    logic [core_pkg::D_WIDTH-1:0]        f_d;
    logic [core_pkg::A_WIDTH-1:0]        f_a;
    logic [core_pkg::B_WIDTH-1:0]        f_b;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0] d_mem;

    assign f_op = instr[core_pkg::WORD_WIDTH-1 -: core_pkg::OPCODE_WIDTH];
    assign f_d = instr[AB_WIDTH +: core_pkg::D_WIDTH];
    assign f_a = instr[core_pkg::B_WIDTH +: core_pkg::A_WIDTH];
    assign f_b = instr[core_pkg::B_WIDTH-1:0];

    // Sums wrap at the memory size
    assign d_mem = f_d[core_pkg::MEM_ADDR_WIDTH-1:0] + d_offset;

    // ------------------------------------------------------------------------
    // Default offsets, one per operand

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            a_offset <= '0;
            b_offset <= '0;
            d_offset <= '0;
        end else if (offset_we) begin
            case (offset_sel)
                host_bus_pkg::OFFSET_A: a_offset <= offset_wdata;
                host_bus_pkg::OFFSET_B: b_offset <= offset_wdata;
                host_bus_pkg::OFFSET_D: d_offset <= offset_wdata;
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Translated operand register

    always_ff @(posedge clock) begin
        if (!stall) begin
            op <= core_pkg::opcode_t'(f_op);
            a_addr <= (f_a == core_pkg::IO_READ_ADDR) ? f_a : f_a + a_offset;
            b_addr <= f_b + b_offset;
            // Output port and unmapped D space are not shifted
            d_addr <= f_d[core_pkg::D_WIDTH-1] ? f_d : {{D_PAD{1'b0}}, d_mem};
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
        end else if (!stall) begin
            op_valid <= instr_valid;
        end
    end

endmodule

/* src/scalar_cpu.sv */
// Scalar core top level with host loader and shared A/B write port

`timescale 1ns/1ps

module scalar_cpu #(
    parameter int I_ADDR_WIDTH = 6
) (
    input  logic                                     clock,
    input  logic                                     rst_n,
    input  logic                                     run,
    input  logic                                     awvalid,
    output logic                                     awready,
    input  logic [host_bus_pkg::HOST_ADDR_WIDTH-1:0] awaddr,
    input  logic                                     wvalid,
    output logic                                     wready,
    input  logic [core_pkg::WORD_WIDTH-1:0]          wdata,
    output logic                                     bvalid,
    input  logic                                     bready,
    output host_bus_pkg::axi_resp_t                  bresp,
    input  logic [core_pkg::WORD_WIDTH-1:0]          io_in,
    input  logic                                     io_in_empty,
    output logic                                     io_rden,
    output logic [core_pkg::WORD_WIDTH-1:0]          io_out,
    input  logic                                     io_out_full,
    output logic                                     io_wren
);

    logic                                    stall;
    logic                                    imem_we;
    logic [I_ADDR_WIDTH-1:0]                 imem_waddr;
    logic [core_pkg::WORD_WIDTH-1:0]         imem_wdata;
    logic [core_pkg::WORD_WIDTH-1:0]         instr;
    logic                                    instr_valid;
    logic                                    offset_we;
    logic [1:0]                              offset_sel;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0]     offset_wdata;
    core_pkg::opcode_t                       op;
    logic [core_pkg::D_WIDTH-1:0]            d_addr;
    logic [core_pkg::A_WIDTH-1:0]            a_addr;
    logic [core_pkg::B_WIDTH-1:0]            b_addr;
    logic                                    op_valid;
    logic                                    core_we;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0]     core_waddr;
    logic [core_pkg::WORD_WIDTH-1:0]         core_wdata;
    logic                                    host_req;
    logic                                    host_gnt;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0]     host_waddr;
    logic [core_pkg::WORD_WIDTH-1:0]         host_wdata;
    logic                                    mem_we;
    logic [core_pkg::MEM_ADDR_WIDTH-1:0]     mem_waddr;
    logic [core_pkg::WORD_WIDTH-1:0]         mem_wdata;

    control_path #(
        .I_ADDR_WIDTH (I_ADDR_WIDTH)
    ) u_control_path (
        .clock, .rst_n, .run, .stall,
        .imem_we, .imem_waddr, .imem_wdata,
        .instr, .instr_valid
    );

    operand_translate u_operand_translate (
        .clock, .rst_n, .stall, .instr, .instr_valid,
        .offset_we, .offset_sel, .offset_wdata,
        .op, .d_addr, .a_addr, .b_addr, .op_valid
    );

    data_path u_data_path (
        .clock, .rst_n, .op, .d_addr, .a_addr, .b_addr, .op_valid,
        .io_in, .io_in_empty, .io_out_full,
        .stall, .io_rden, .io_out, .io_wren,
        .core_we, .core_waddr, .core_wdata,
        .mem_we, .mem_waddr, .mem_wdata
    );

    host_loader #(
        .I_ADDR_WIDTH (I_ADDR_WIDTH)
    ) u_host_loader (
        .clock, .rst_n,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .bresp,
        .imem_we, .imem_waddr, .imem_wdata,
        .offset_we, .offset_sel, .offset_wdata,
        .host_req, .host_waddr, .host_wdata, .host_gnt
    );

    mem_write_arbiter u_mem_write_arbiter (
        .core_we, .core_waddr, .core_wdata,
        .host_req, .host_waddr, .host_wdata,
        .host_gnt, .mem_we, .mem_waddr, .mem_wdata
    );

endmodule

/* verif/tb_scalar_cpu.sv */
// Directed testbench for the scalar core
// AXI loader tasks, I/O port models, a reference model of the core and a watchdog

`timescale 1ns/1ps

module tb_scalar_cpu;

    localparam int I_ADDR_WIDTH = 6;
    localparam int IMEM_DEPTH = 2 ** I_ADDR_WIDTH;
    localparam int AXI_CYCLES = 4;
    localparam int RUN_CYCLES = 80;
    localparam int TEST_CYCLES = 8 + 7 * (IMEM_DEPTH * AXI_CYCLES + RUN_CYCLES) + 80 * AXI_CYCLES;
    localparam int WAIT_LIMIT = 200;

    // Host word address bases, region select in bits 13:12
    localparam logic [15:0] IMEM_BASE = 16'h0000;
    localparam logic [15:0] DMEM_BASE = 16'h1000;
    localparam logic [15:0] OFFSET_BASE = 16'h2000;

    localparam logic [9:0] OUT_D = 10'd512;
    localparam logic [8:0] IN_A = 9'd511;

    logic                     clock = 1'b0;
    logic                     rst_n;
    logic                     run;
    logic                     awvalid;
    logic                     awready;
    logic [15:0]              awaddr;
    logic                     wvalid;
    logic                     wready;
    logic [31:0]              wdata;
    logic                     bvalid;
    logic                     bready;
    host_bus_pkg::axi_resp_t  bresp;
    logic [31:0]              io_in;
    logic                     io_in_empty;
    logic                     io_rden;
    logic [31:0]              io_out;
    logic                     io_out_full;
    logic                     io_wren;

    logic [31:0] prog_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] out_q[$];
    logic [31:0] in_q[$];
    logic [31:0] model_in_q[$];
    logic [31:0] mem_model [512];
    logic [8:0]  off_a;
    logic [8:0]  off_b;
    logic [8:0]  off_d;
    logic        rden_seen = 1'b0;
    int          rden_count = 0;
    int          in_ptr;

    scalar_cpu #(
        .I_ADDR_WIDTH (I_ADDR_WIDTH)
    ) UUT (.*);

    always #5 clock = ~clock;

    // ------------------------------------------------------------------------
    // Failure reporting

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "run stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        stop_run($sformatf("CHECK FAILED at time %0t: %s expected %h, actual %h",
                           $time, name, expected, actual));
    endtask

    // ------------------------------------------------------------------------
    // I/O port models

    // Output monitor and input read tracking at the falling edge
    always @(negedge clock) begin
        if (rst_n && io_wren) begin
            out_q.push_back(io_out);
        end
        if (rst_n && io_rden) begin
            assert (!io_in_empty) else stop_run("Input port was read while empty");
            rden_count++;
        end
        rden_seen = rst_n && io_rden;
    end

    // Show-ahead input FIFO that moves to the next word after each read
    initial begin
        in_ptr = 0;
        io_in = '0;
        io_in_empty = 1'b1;
        forever begin
            @(posedge clock);
            #1;
            if (rden_seen) begin
                in_ptr++;
            end
            io_in_empty = (in_ptr >= in_q.size());
            io_in = io_in_empty ? '0 : in_q[in_ptr];
        end
    end

    initial begin
        repeat (TEST_CYCLES * 20) @(posedge clock);
        stop_run("Watchdog expired before the tests finished");
    end

    // ------------------------------------------------------------------------
    // Host bus tasks

    task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                             input host_bus_pkg::axi_resp_t exp_resp);
        int waited;
        waited = 0;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        @(negedge clock);
        while (!awready) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_run("AXI write was never accepted");
            @(negedge clock);
        end
        assert (wready) else report_mismatch("wready", 32'd1, 32'(wready));
        @(posedge clock);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        @(negedge clock);
        while (!bvalid) begin
            waited++;
            if (waited > WAIT_LIMIT) stop_run("AXI write response never arrived");
            @(negedge clock);
        end
        assert (bresp == exp_resp) else report_mismatch("bresp", 32'(exp_resp), 32'(bresp));
        @(posedge clock);
        #1;
    endtask

    task automatic dmem_write(input logic [8:0] addr, input logic [31:0] data);
        axi_write(DMEM_BASE | {7'd0, addr}, data, host_bus_pkg::RESP_OKAY);
        mem_model[addr] = data;
    endtask

    task automatic fill_random(input int base, input int count);
        for (int k = 0; k < count; k++) begin
            dmem_write(9'(base + k), $urandom());
        end
    endtask

    task automatic set_offsets(input logic [8:0] a, input logic [8:0] b, input logic [8:0] d);
        axi_write(OFFSET_BASE, {23'd0, a}, host_bus_pkg::RESP_OKAY);
        axi_write(OFFSET_BASE + 16'd1, {23'd0, b}, host_bus_pkg::RESP_OKAY);
        axi_write(OFFSET_BASE + 16'd2, {23'd0, d}, host_bus_pkg::RESP_OKAY);
        off_a = a;
        off_b = b;
        off_d = d;
    endtask

    // ------------------------------------------------------------------------
    // Program building and reference model

    function automatic logic [31:0] alu_expect(input logic [3:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        case (op)
            core_pkg::ADD:    return a + b;
            core_pkg::SUB:    return a - b;
            core_pkg::AND:    return a & b;
            core_pkg::OR:     return a | b;
            core_pkg::XOR:    return a ^ b;
            default:          return a;
        endcase
    endfunction

    task automatic add_instr(input logic [3:0] op, input logic [9:0] d, input logic [8:0] a,
                             input logic [8:0] b);
        prog_q.push_back({op, d, a, b});
    endtask

    task automatic add_nops(input int count);
        for (int k = 0; k < count; k++) begin
            add_instr(core_pkg::NOP, 10'd0, 9'd0, 9'd0);
        end
    endtask

    // Runs the program on the model with offsets modulo 512 and I/O addresses untranslated
    task automatic model_program();
        logic [3:0]  op;
        logic [9:0]  d;
        logic [8:0]  a;
        logic [8:0]  b;
        logic [8:0]  a_idx;
        logic [8:0]  b_idx;
        logic [8:0]  d_idx;
        logic [31:0] a_val;
        logic [31:0] result;
        exp_q.delete();
        foreach (prog_q[i]) begin
            {op, d, a, b} = prog_q[i];
            // Only ADD through PASS_A act
            if (op >= 4'd1 && op <= 4'd6) begin
                a_idx = a + off_a;
                b_idx = b + off_b;
                d_idx = d[8:0] + off_d;
                a_val = (a == IN_A) ? model_in_q.pop_front() : mem_model[a_idx];
                result = alu_expect(op, a_val, mem_model[b_idx]);
                if (d == OUT_D) begin
                    exp_q.push_back(result);
                end else if (!d[9]) begin
                    mem_model[d_idx] = result;
                end
            end
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            axi_write(IMEM_BASE + 16'(i), (i < prog_q.size()) ? prog_q[i] : 32'h0,
                      host_bus_pkg::RESP_OKAY);
        end
        model_program();
    endtask

    // Runs until all expected outputs arrived, then drains and compares in order
    task automatic expect_outputs(input int first);
        int waited;
        waited = 0;
        run = 1'b1;
        while (out_q.size() - first < exp_q.size()) begin
            @(posedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stop_run("Expected outputs did not arrive");
        end
        run = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        assert (out_q.size() - first == exp_q.size())
            else report_mismatch("io_wren count", exp_q.size(), out_q.size() - first);
        foreach (exp_q[i]) begin
            assert (out_q[first + i] == exp_q[i])
                else report_mismatch("io_out", exp_q[i], out_q[first + i]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests

    task automatic address_map_test();
        dmem_write(9'd2, $urandom());
        dmem_write(9'd3, $urandom());
        set_offsets(9'd0, 9'd0, 9'd0);
        prog_q.delete();
        add_instr(core_pkg::PASS_A, OUT_D, 9'd2, 9'd0);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd3, 9'd0);
        add_instr(core_pkg::ADD, 10'd20, 9'd2, 9'd3);
        add_nops(3);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd20, 9'd0);
        load_program();
        // Unmapped address aliases IMEM word 2, DMEM word 2 and the D offset
        axi_write(16'h3002, $urandom(), host_bus_pkg::RESP_SLVERR);
        expect_outputs(out_q.size());
    endtask

    task automatic alu_test();
        fill_random(30, 8);
        fill_random(40, 8);
        prog_q.delete();
        add_instr(core_pkg::ADD, OUT_D, 9'd30, 9'd40);
        add_instr(core_pkg::SUB, OUT_D, 9'd31, 9'd41);
        add_instr(core_pkg::AND, OUT_D, 9'd32, 9'd42);
        add_instr(core_pkg::NOP, OUT_D, 9'd37, 9'd47);
        add_instr(core_pkg::OR, OUT_D, 9'd33, 9'd43);
        add_instr(4'hf, OUT_D, 9'd34, 9'd44);
        add_instr(core_pkg::XOR, OUT_D, 9'd35, 9'd45);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd36, 9'd46);
        load_program();
        expect_outputs(out_q.size());
    endtask

    task automatic offset_test();
        logic [31:0] word;
        set_offsets(9'd400, 9'd300, 9'd450);
        fill_random(430, 2);
        fill_random(340, 3);
        word = $urandom();
        model_in_q.push_back(word);
        in_q.push_back(word);
        prog_q.delete();
        add_instr(core_pkg::ADD, OUT_D, 9'd30, 9'd40);
        add_instr(core_pkg::SUB, 10'd100, 9'd31, 9'd41);
        add_nops(3);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd150, 9'd0);
        add_instr(core_pkg::ADD, OUT_D, IN_A, 9'd42);
        load_program();
        expect_outputs(out_q.size());
        assert (in_ptr == in_q.size())
            else report_mismatch("input words read", in_q.size(), in_ptr);
        set_offsets(9'd0, 9'd0, 9'd0);
    endtask

    task automatic input_backpressure_test();
        logic [31:0] words[3];
        int          first;
        int          reads_before;
        fill_random(50, 3);
        foreach (words[k]) begin
            words[k] = $urandom();
            model_in_q.push_back(words[k]);
        end
        prog_q.delete();
        add_instr(core_pkg::ADD, OUT_D, IN_A, 9'd50);
        add_instr(core_pkg::XOR, OUT_D, IN_A, 9'd51);
        add_instr(core_pkg::SUB, 10'd60, IN_A, 9'd52);
        add_nops(3);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd60, 9'd0);
        load_program();
        first = out_q.size();
        reads_before = rden_count;
        run = 1'b1;
        repeat (30) @(posedge clock);
        #1;
        assert (out_q.size() == first)
            else report_mismatch("io_wren count", 0, out_q.size() - first);
        assert (rden_count == reads_before)
            else report_mismatch("io_rden count", 0, rden_count - reads_before);
        foreach (words[k]) begin
            in_q.push_back(words[k]);
        end
        expect_outputs(first);
        assert (rden_count - reads_before == 3)
            else report_mismatch("io_rden count", 3, rden_count - reads_before);
    endtask

    task automatic output_backpressure_test();
        int first;
        fill_random(70, 5);
        prog_q.delete();
        add_instr(core_pkg::PASS_A, OUT_D, 9'd70, 9'd0);
        add_instr(core_pkg::ADD, OUT_D, 9'd71, 9'd72);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd72, 9'd0);
        add_instr(core_pkg::SUB, OUT_D, 9'd73, 9'd74);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd74, 9'd0);
        load_program();
        first = out_q.size();
        io_out_full = 1'b1;
        run = 1'b1;
        repeat (30) @(posedge clock);
        #1;
        assert (out_q.size() == first)
            else report_mismatch("io_wren count", 0, out_q.size() - first);
        io_out_full = 1'b0;
        expect_outputs(first);
    endtask

    task automatic shared_port_test();
        logic [31:0] host_words[6];
        fill_random(80, 1);
        foreach (host_words[k]) begin
            host_words[k] = $urandom();
        end
        prog_q.delete();
        for (int k = 0; k < 12; k++) begin
            add_instr(core_pkg::PASS_A, 10'(200 + k), 9'd80, 9'd0);
        end
        add_nops(3);
        add_instr(core_pkg::PASS_A, OUT_D, 9'd211, 9'd0);
        load_program();
        // Host data writes race the stream of core result writes
        fork
            expect_outputs(out_q.size());
            begin
                for (int k = 0; k < 6; k++) begin
                    dmem_write(9'(300 + k), host_words[k]);
                end
            end
        join
        prog_q.delete();
        for (int k = 0; k < 6; k++) begin
            add_instr(core_pkg::PASS_A, OUT_D, 9'(300 + k), 9'd0);
        end
        load_program();
        expect_outputs(out_q.size());
    endtask

    initial begin
        void'($urandom(32'h7f91_6e04));
        rst_n = 1'b0;
        run = 1'b0;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b1;
        io_out_full = 1'b0;
        off_a = '0;
        off_b = '0;
        off_d = '0;
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
        address_map_test();
        alu_test();
        offset_test();
        input_backpressure_test();
        output_backpressure_test();
        shared_port_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
